// ==== source/fetch_pkg.sv ====
package fetch_pkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int word_w = 16;
   localparam int addr_w = 16;
   localparam int reg_idx_w = 4;
   localparam int num_base_regs = 1 << reg_idx_w;

   // four slots per bundle, one bank per slot
   localparam int bundle_width = 4;
   localparam int imem_depth = 256;
   localparam int bank_depth = imem_depth / bundle_width;
   localparam int bank_bits = $clog2(bundle_width);
   localparam int row_bits = $clog2(bank_depth);

   // bundles the downstream can buffer
   localparam int credit_depth = 4;
   localparam int credit_w = $clog2(credit_depth + 1);

   ////////////////////
   // jump encoding
   ////////////////////
   localparam logic [3:0] jump_opcode = 4'hf;
   localparam int op_msb = 15;
   localparam int op_lsb = 12;
   // bit 0 set means register jump
   localparam int reg_flag_bit = 0;
   // pc relative offset
   localparam int imm_off_msb = 11;
   localparam int imm_off_lsb = 2;
   localparam int imm_off_w = imm_off_msb - imm_off_lsb + 1;
   // base register and its offset
   localparam int base_idx_msb = 11;
   localparam int base_idx_lsb = 8;
   localparam int reg_off_msb = 7;
   localparam int reg_off_lsb = 2;
   localparam int reg_off_w = reg_off_msb - reg_off_lsb + 1;

   typedef logic [word_w-1:0] word_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;
   typedef logic [bundle_width-1:0] slot_mask_t;
   typedef logic [bank_bits-1:0] slot_idx_t;
   typedef logic [row_bits-1:0] row_t;
   typedef logic [credit_w-1:0] credit_t;

   typedef enum logic [1:0] {
      idle,
      wait_base,
      issue_base
   } resolve_state_t;

endpackage

// ==== source/imem_bank.sv ====
`timescale 1ns/1ps

module imem_bank (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             wr_en,
   input  fetch_pkg::addr_t wr_addr,
   input  fetch_pkg::word_t wr_data,
   input  logic             rd_en,
   input  fetch_pkg::addr_t rd_addr,
   output fetch_pkg::word_t rd_word0,
   output fetch_pkg::word_t rd_word1,
   output fetch_pkg::word_t rd_word2,
   output fetch_pkg::word_t rd_word3,
   output logic             rd_valid
);
   import fetch_pkg::*;

   word_t     bank_mem [bundle_width][bank_depth];
   word_t     bank_q [bundle_width];
   word_t     rot_word [bundle_width];
   row_t      rd_row [bundle_width];
   row_t      base_row;
   slot_idx_t base_bank;
   slot_idx_t rd_rot;
   slot_idx_t wr_bank;
   row_t      wr_row;

   // low bits pick the bank, the rest the row
   // upper address bits dropped, so reads wrap
   assign base_bank = rd_addr[bank_bits-1:0];
   assign base_row = rd_addr[bank_bits +: row_bits];
   assign wr_bank = wr_addr[bank_bits-1:0];
   assign wr_row = wr_addr[bank_bits +: row_bits];

   // banks below the start bank hold the words of the next row
   always_comb begin
      for (int b = 0; b < bundle_width; b++) begin
         if (slot_idx_t'(b) < base_bank)
            rd_row[b] = base_row + row_t'(1);
         else
            rd_row[b] = base_row;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < bundle_width; b++) begin
         if (wr_en && wr_bank == slot_idx_t'(b))
            bank_mem[b][wr_row] <= wr_data;
         if (rd_en)
            bank_q[b] <= bank_mem[b][rd_row[b]];
      end
      if (rd_en)
         rd_rot <= base_bank;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

   // rotate so that slot 0 is the word at rd_addr
   always_comb begin
      for (int s = 0; s < bundle_width; s++)
         rot_word[s] = bank_q[slot_idx_t'(rd_rot + s)];
   end

   assign rd_word0 = rot_word[0];
   assign rd_word1 = rot_word[1];
   assign rd_word2 = rot_word[2];
   assign rd_word3 = rot_word[3];

endmodule

// ==== source/imem_arbiter.sv ====
`timescale 1ns/1ps

module imem_arbiter (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             load_en,
   input  fetch_pkg::addr_t load_addr,
   input  fetch_pkg::word_t load_data,
   input  logic             fetch_req,
   input  fetch_pkg::addr_t fetch_addr,
   output logic             fetch_gnt,
   output fetch_pkg::word_t fetch_word0,
   output fetch_pkg::word_t fetch_word1,
   output fetch_pkg::word_t fetch_word2,
   output fetch_pkg::word_t fetch_word3,
   output logic             fetch_valid
);
   import fetch_pkg::*;

   addr_t port_addr;
   logic  port_rd;
   word_t bank_word0;
   word_t bank_word1;
   word_t bank_word2;
   word_t bank_word3;
   logic  bank_valid;

   // loader always wins, fetch only on an idle port
   assign fetch_gnt = fetch_req && !load_en;
   assign port_rd = fetch_gnt;

   // single address into the memory
   assign port_addr = load_en ? load_addr : fetch_addr;

   imem_bank u_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (load_en),
      .wr_addr  (port_addr),
      .wr_data  (load_data),
      .rd_en    (port_rd),
      .rd_addr  (port_addr),
      .rd_word0 (bank_word0),
      .rd_word1 (bank_word1),
      .rd_word2 (bank_word2),
      .rd_word3 (bank_word3),
      .rd_valid (bank_valid)
   );

   // data goes back only for a granted fetch
   assign fetch_valid = bank_valid;
   assign fetch_word0 = bank_valid ? bank_word0 : '0;
   assign fetch_word1 = bank_valid ? bank_word1 : '0;
   assign fetch_word2 = bank_valid ? bank_word2 : '0;
   assign fetch_word3 = bank_valid ? bank_word3 : '0;

endmodule

// ==== source/base_reg_file.sv ====
`timescale 1ns/1ps

module base_reg_file (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wr_en,
   input  fetch_pkg::reg_idx_t  wr_idx,
   input  fetch_pkg::word_t     wr_data,
   input  logic                 rd_en,
   input  fetch_pkg::reg_idx_t  rd_idx,
   output fetch_pkg::word_t     rd_data
);
   import fetch_pkg::*;

   word_t regs [num_base_regs];

   ////////////////////
   // write port
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_base_regs; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   ////////////////////
   // read port
   ////////////////////
   // one cycle latency, value held until the next read
   // same cycle write lands after the read, so old value
   always_ff @(posedge clk) begin
      if (rd_en)
         rd_data <= regs[rd_idx];
   end

endmodule

// ==== source/jump_resolver.sv ====
`timescale 1ns/1ps

module jump_resolver (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  fetch_pkg::addr_t    in_pc,
   input  fetch_pkg::word_t    in_word0,
   input  fetch_pkg::word_t    in_word1,
   input  fetch_pkg::word_t    in_word2,
   input  fetch_pkg::word_t    in_word3,
   input  logic                flush,
   output logic                base_rd_en,
   output fetch_pkg::reg_idx_t base_rd_idx,
   input  fetch_pkg::word_t    base_rd_data,
   output logic                out_valid,
   output fetch_pkg::addr_t    out_pc,
   output fetch_pkg::word_t    out_word0,
   output fetch_pkg::word_t    out_word1,
   output fetch_pkg::word_t    out_word2,
   output fetch_pkg::word_t    out_word3,
   output logic                jump_taken,
   output fetch_pkg::addr_t    jump_target,
   output logic                hold
);
   import fetch_pkg::*;

   resolve_state_t state;
   resolve_state_t state_nxt;
   word_t          slot_word [bundle_width];
   word_t          kept_word [bundle_width];
   slot_mask_t     is_jump;
   slot_mask_t     keep_mask;
   slot_idx_t      jump_slot;
   word_t          jump_word;
   logic           any_jump;
   logic           jump_is_reg;
   logic           take_bundle;
   logic           imm_taken;
   logic           reg_start;
   addr_t          imm_target;
   addr_t          reg_offset;
   addr_t          reg_offset_q;

   assign slot_word[0] = in_word0;
   assign slot_word[1] = in_word1;
   assign slot_word[2] = in_word2;
   assign slot_word[3] = in_word3;

   // new bundles only when idle and not being flushed
   assign take_bundle = in_valid && !flush && (state == idle);

   ////////////////////
   // slot decode
   ////////////////////
   always_comb begin
      for (int s = 0; s < bundle_width; s++)
         is_jump[s] = slot_word[s][op_msb:op_lsb] == jump_opcode;
   end

   // lowest jump wins, the jump slot itself is kept
   always_comb begin
      logic found;
      found = 1'b0;
      keep_mask = '0;
      jump_slot = '0;
      for (int s = 0; s < bundle_width; s++) begin
         keep_mask[s] = !found;
         if (is_jump[s] && !found)
            jump_slot = slot_idx_t'(s);
         found = found | is_jump[s];
      end
   end

   assign any_jump = |is_jump;
   assign jump_word = slot_word[jump_slot];
   assign jump_is_reg = jump_word[reg_flag_bit];

   assign imm_taken = take_bundle && any_jump && !jump_is_reg;
   assign reg_start = take_bundle && any_jump && jump_is_reg;

   ////////////////////
   // targets
   ////////////////////
   // slot address plus one plus sign extended offset
   assign imm_target = in_pc + addr_t'(jump_slot) + addr_t'(1)
                     + {{(addr_w - imm_off_w){jump_word[imm_off_msb]}},
                        jump_word[imm_off_msb:imm_off_lsb]};

   assign reg_offset = {{(addr_w - reg_off_w){jump_word[reg_off_msb]}},
                        jump_word[reg_off_msb:reg_off_lsb]};

   // offset waits here until the base comes back
   always_ff @(posedge clk) begin
      if (reg_start)
         reg_offset_q <= reg_offset;
   end

   ////////////////////
   // register jump FSM
   ////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         idle:       if (reg_start) state_nxt = wait_base;
         wait_base:  state_nxt = issue_base;
         issue_base: state_nxt = idle;
         default:    state_nxt = idle;
      endcase
      // redirect or stale data drops the wait
      if (flush)
         state_nxt = idle;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= idle;
      else
         state <= state_nxt;
   end

   // base read goes out with the squashed bundle
   assign base_rd_en = reg_start;
   assign base_rd_idx = jump_word[base_idx_msb:base_idx_lsb];

   assign hold = (state == wait_base);

   assign jump_taken = imm_taken || (state == issue_base && !flush);
   assign jump_target = (state == issue_base) ? base_rd_data + reg_offset_q : imm_target;

   // slots behind the jump become nops
   always_comb begin
      for (int s = 0; s < bundle_width; s++)
         kept_word[s] = keep_mask[s] ? slot_word[s] : '0;
   end

   assign out_valid = take_bundle;
   assign out_pc = in_pc;
   assign out_word0 = kept_word[0];
   assign out_word1 = kept_word[1];
   assign out_word2 = kept_word[2];
   assign out_word3 = kept_word[3];

endmodule

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             redirect_en,
   input  fetch_pkg::addr_t redirect_pc,
   input  logic             jump_taken,
   input  fetch_pkg::addr_t jump_target,
   input  logic             hold,
   input  logic             fetch_gnt,
   output logic             fetch_req,
   output fetch_pkg::addr_t fetch_addr,
   input  logic             res_valid,
   input  fetch_pkg::addr_t res_pc,
   input  fetch_pkg::word_t res_word0,
   input  fetch_pkg::word_t res_word1,
   input  fetch_pkg::word_t res_word2,
   input  fetch_pkg::word_t res_word3,
   output logic             flush,
   input  logic             credit_return,
   output logic             bundle_valid,
   output fetch_pkg::addr_t bundle_pc,
   output fetch_pkg::word_t bundle_word0,
   output fetch_pkg::word_t bundle_word1,
   output fetch_pkg::word_t bundle_word2,
   output fetch_pkg::word_t bundle_word3
);
   import fetch_pkg::*;

   addr_t   pc;
   logic    epoch;
   logic    req_epoch;
   logic    inflight;
   credit_t credits;
   logic    grant;
   logic    refund;

   // a credit is taken at the grant, so in-flight requests count
   assign fetch_req = (credits != '0) && !hold;
   assign fetch_addr = pc;
   assign grant = fetch_req && fetch_gnt;

   // returning data from an older epoch is thrown away
   assign flush = redirect_en || (inflight && req_epoch != epoch);
   // request came back without a bundle, give its credit back
   assign refund = inflight && !res_valid;

   ////////////////////
   // pc, epoch, credits
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
         epoch <= 1'b0;
         req_epoch <= 1'b0;
         inflight <= 1'b0;
         credits <= credit_t'(credit_depth);
         bundle_valid <= 1'b0;
      end else begin
         // redirect, then jump, then next bundle, else hold
         if (redirect_en)
            pc <= redirect_pc;
         else if (jump_taken)
            pc <= jump_target;
         else if (grant)
            pc <= pc + addr_t'(bundle_width);
         if (redirect_en || jump_taken)
            epoch <= !epoch;
         if (grant)
            req_epoch <= epoch;
         inflight <= grant;
         credits <= credits + credit_t'(credit_return) + credit_t'(refund)
                  - credit_t'(grant);
         bundle_valid <= res_valid;
      end
   end

   // bundle payload
   always_ff @(posedge clk) begin
      if (res_valid) begin
         bundle_pc <= res_pc;
         bundle_word0 <= res_word0;
         bundle_word1 <= res_word1;
         bundle_word2 <= res_word2;
         bundle_word3 <= res_word3;
      end
   end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load_en,
   input  fetch_pkg::addr_t    load_addr,
   input  fetch_pkg::word_t    load_data,
   input  logic                reg_wr_en,
   input  fetch_pkg::reg_idx_t reg_wr_idx,
   input  fetch_pkg::word_t    reg_wr_data,
   input  logic                redirect_en,
   input  fetch_pkg::addr_t    redirect_pc,
   input  logic                credit_return,
   output logic                bundle_valid,
   output fetch_pkg::addr_t    bundle_pc,
   output fetch_pkg::word_t    bundle_word0,
   output fetch_pkg::word_t    bundle_word1,
   output fetch_pkg::word_t    bundle_word2,
   output fetch_pkg::word_t    bundle_word3
);
   import fetch_pkg::*;

   // memory port
   logic     fetch_req;
   logic     fetch_gnt;
   addr_t    fetch_addr;
   addr_t    fetch_addr_q;
   logic     rd_valid;
   word_t    rd_word0;
   word_t    rd_word1;
   word_t    rd_word2;
   word_t    rd_word3;
   // base register read
   logic     base_rd_en;
   reg_idx_t base_rd_idx;
   word_t    base_rd_data;
   // resolver to sequencer
   logic     res_valid;
   addr_t    res_pc;
   word_t    res_word0;
   word_t    res_word1;
   word_t    res_word2;
   word_t    res_word3;
   logic     jump_taken;
   addr_t    jump_target;
   logic     hold;
   logic     flush;

   // address of the bundle now coming back from memory
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         fetch_addr_q <= '0;
      else
         fetch_addr_q <= fetch_addr;
   end

   imem_arbiter u_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .fetch_gnt   (fetch_gnt),
      .fetch_word0 (rd_word0),
      .fetch_word1 (rd_word1),
      .fetch_word2 (rd_word2),
      .fetch_word3 (rd_word3),
      .fetch_valid (rd_valid)
   );

   base_reg_file u_base_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (reg_wr_en),
      .wr_idx  (reg_wr_idx),
      .wr_data (reg_wr_data),
      .rd_en   (base_rd_en),
      .rd_idx  (base_rd_idx),
      .rd_data (base_rd_data)
   );

   jump_resolver u_resolver (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (rd_valid),
      .in_pc        (fetch_addr_q),
      .in_word0     (rd_word0),
      .in_word1     (rd_word1),
      .in_word2     (rd_word2),
      .in_word3     (rd_word3),
      .flush        (flush),
      .base_rd_en   (base_rd_en),
      .base_rd_idx  (base_rd_idx),
      .base_rd_data (base_rd_data),
      .out_valid    (res_valid),
      .out_pc       (res_pc),
      .out_word0    (res_word0),
      .out_word1    (res_word1),
      .out_word2    (res_word2),
      .out_word3    (res_word3),
      .jump_taken   (jump_taken),
      .jump_target  (jump_target),
      .hold         (hold)
   );

   fetch_sequencer u_sequencer (
      .clk           (clk),
      .rst_n         (rst_n),
      .redirect_en   (redirect_en),
      .redirect_pc   (redirect_pc),
      .jump_taken    (jump_taken),
      .jump_target   (jump_target),
      .hold          (hold),
      .fetch_gnt     (fetch_gnt),
      .fetch_req     (fetch_req),
      .fetch_addr    (fetch_addr),
      .res_valid     (res_valid),
      .res_pc        (res_pc),
      .res_word0     (res_word0),
      .res_word1     (res_word1),
      .res_word2     (res_word2),
      .res_word3     (res_word3),
      .flush         (flush),
      .credit_return (credit_return),
      .bundle_valid  (bundle_valid),
      .bundle_pc     (bundle_pc),
      .bundle_word0  (bundle_word0),
      .bundle_word1  (bundle_word1),
      .bundle_word2  (bundle_word2),
      .bundle_word3  (bundle_word3)
   );

endmodule

// ==== test/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load_en,
   input  fetch_pkg::addr_t    load_addr,
   input  fetch_pkg::word_t    load_data,
   input  logic                reg_wr_en,
   input  fetch_pkg::reg_idx_t reg_wr_idx,
   input  fetch_pkg::word_t    reg_wr_data,
   input  logic                redirect_en,
   input  fetch_pkg::addr_t    redirect_pc,
   input  logic                credit_return,
   input  logic                bundle_valid,
   input  fetch_pkg::addr_t    bundle_pc,
   input  fetch_pkg::word_t    bundle_word0,
   input  fetch_pkg::word_t    bundle_word1,
   input  fetch_pkg::word_t    bundle_word2,
   input  fetch_pkg::word_t    bundle_word3,
   input  int                  test_id,
   output int                  test_bundles,
   output int                  total_bundles,
   output int                  total_errors
);
   import fetch_pkg::*;

   // mirrors of what the loader and register port wrote
   word_t mem [imem_depth];
   word_t regs [16];

   int    cur_test = 0;
   int    test_errors = 0;
   int    outstanding = 0;
   logic  synced = 1'b0;
   logic  pending = 1'b0;
   addr_t exp_pc = '0;
   addr_t resync_pc = '0;

   function automatic string test_name(int id);
      case (id)
         1: return "straight_line";
         2: return "imm_jumps";
         3: return "reg_jumps";
         4: return "credit_pressure";
         5: return "redirect";
         6: return "load_priority";
         default: return "none";
      endcase
   endfunction

   ////////////////////
   // reference model
   ////////////////////
   // one bundle from pc: {next pc, word3, word2, word1, word0}
   function automatic logic [79:0] ref_bundle(addr_t pc);
      word_t w [4];
      word_t j;
      addr_t next;
      logic  hit;
      next = pc + 16'd4;
      hit = 1'b0;
      for (int s = 0; s < 4; s++) begin
         // memory wraps, the pc does not
         j = mem[(int'(pc) + s) % imem_depth];
         if (hit) begin
            w[s] = '0;
         end else begin
            w[s] = j;
            if (j[15:12] == 4'hf) begin
               hit = 1'b1;
               // bit 0 picks register jump over pc relative
               if (j[0])
                  next = regs[j[11:8]] + {{10{j[7]}}, j[7:2]};
               else
                  next = pc + addr_t'(s) + 16'd1 + {{6{j[11]}}, j[11:2]};
            end
         end
      end
      return {next, w[3], w[2], w[1], w[0]};
   endfunction

   task automatic flag_value(string what, logic [15:0] expected, logic [15:0] actual);
      $display("ERROR %s %s expected %h actual %h",
               test_name(cur_test), what, expected, actual);
      test_errors++;
      total_errors++;
   endtask

   task automatic flag_event(string what);
      $display("test %s: %s", test_name(cur_test), what);
      test_errors++;
      total_errors++;
   endtask

   ////////////////////
   // compare
   ////////////////////
   always @(posedge clk) begin
      logic [79:0] exp;
      logic [63:0] got;
      if (!rst_n) begin
         for (int r = 0; r < 16; r++)
            regs[r] = '0;
         outstanding = 0;
         synced = 1'b0;
         pending = 1'b0;
      end else begin
         // new id closes the running test
         if (test_id != cur_test) begin
            if (cur_test != 0)
               $display("test %-16s %0d bundles, %0d errors",
                        test_name(cur_test), test_bundles, test_errors);
            if (test_id == 0)
               synced = 1'b0;
            cur_test = test_id;
            test_bundles = 0;
            test_errors = 0;
         end

         // a bundle seen now left before any redirect seen now
         if (bundle_valid) begin
            outstanding++;
            if (synced) begin
               test_bundles++;
               total_bundles++;
               got = {bundle_word3, bundle_word2, bundle_word1, bundle_word0};
               if (pending && bundle_pc != resync_pc) begin
                  flag_event($sformatf("bundle at pc %h from the old stream after redirect to %h",
                                       bundle_pc, resync_pc));
               end else begin
                  pending = 1'b0;
                  exp = ref_bundle(exp_pc);
                  if (bundle_pc != exp_pc)
                     flag_value("bundle pc", exp_pc, bundle_pc);
                  for (int s = 0; s < 4; s++) begin
                     if (got[16*s +: 16] != exp[16*s +: 16])
                        flag_value($sformatf("word%0d at pc %h", s, exp_pc),
                                   exp[16*s +: 16], got[16*s +: 16]);
                  end
                  exp_pc = exp[79:64];
               end
            end
         end

         // downstream buffer bound
         if (credit_return)
            outstanding--;
         if (outstanding > credit_depth)
            flag_event($sformatf("%0d bundles outstanding with only %0d credits",
                                 outstanding, credit_depth));

         // restart the reference at the redirect pc
         if (redirect_en && cur_test != 0) begin
            exp_pc = redirect_pc;
            resync_pc = redirect_pc;
            pending = 1'b1;
            synced = 1'b1;
         end

         // mirrors last, the bundles above were read earlier
         if (load_en)
            mem[int'(load_addr) % imem_depth] = load_data;
         if (reg_wr_en)
            regs[reg_wr_idx] = reg_wr_data;
      end
   end

endmodule

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
   import fetch_pkg::*;

   localparam int clk_period = 8;
   // bundles waited for in each test
   localparam int n_straight = 12;
   localparam int n_imm = 10;
   localparam int n_reg = 10;
   localparam int n_credit = 24;
   localparam int n_redirect = 20;
   localparam int n_load = 12;
   localparam int cycle_limit =
      (n_straight + n_imm + n_reg + n_credit + n_redirect + n_load) * 20 + 500;

   logic     clk;
   logic     rst_n;
   logic     load_en;
   addr_t    load_addr;
   word_t    load_data;
   logic     reg_wr_en;
   reg_idx_t reg_wr_idx;
   word_t    reg_wr_data;
   logic     redirect_en;
   addr_t    redirect_pc;
   logic     credit_return;
   logic     bundle_valid;
   addr_t    bundle_pc;
   word_t    bundle_word0;
   word_t    bundle_word1;
   word_t    bundle_word2;
   word_t    bundle_word3;

   int          test_id = 0;
   int          test_bundles;
   int          total_bundles;
   int          total_errors;
   int          cycle = 0;
   logic [15:0] lfsr = 16'd62960;
   word_t       prog [imem_depth];
   word_t       base_val [16];
   // downstream model
   int          delay_tab [64];
   int          credit_idx = 0;
   int          credit_due [$];
   logic        slow_credits = 1'b0;

   ////////////////////
   // random source
   ////////////////////
   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr[15]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   // any word but a jump
   function automatic word_t filler_word();
      word_t v;
      v = rand_bits(16);
      if (v[15:12] == 4'hf)
         v[15] = 1'b0;
      return v;
   endfunction

   function automatic word_t imm_jump(addr_t src, addr_t dst);
      addr_t off;
      off = dst - src - 16'd1;
      return {4'hf, off[9:0], 2'b00};
   endfunction

   function automatic word_t reg_jump(reg_idx_t idx, logic [5:0] off);
      return {4'hf, idx, off, 2'b01};
   endfunction

   ////////////////////
   // program layout
   ////////////////////
   // 00-3f straight, 40-7f pc relative chain, 80-bf register chain, c0-cf loop
   task automatic build_program();
      int          slot;
      reg_idx_t    idx;
      logic [15:0] off;
      addr_t       src;
      addr_t       dst;
      for (int a = 0; a < imem_depth; a++)
         prog[a] = filler_word();
      for (int r = 0; r < 16; r++)
         base_val[r] = rand_bits(16);
      // one jump per slot position, one of them backwards
      prog[8'h40] = imm_jump(16'h40, 16'h50);
      prog[8'h51] = imm_jump(16'h51, 16'h60);
      prog[8'h62] = imm_jump(16'h62, 16'h49);
      prog[8'h4c] = imm_jump(16'h4c, 16'h70);
      // base chosen so the chain lands on the next bundle
      for (int k = 0; k < 4; k++) begin
         slot = int'(rand_bits(2));
         idx = reg_idx_t'(4 * k + int'(rand_bits(2)));
         off = rand_bits(6);
         src = addr_t'(16'h80 + 8 * k + slot);
         dst = (k == 3) ? 16'ha2 : addr_t'(16'h88 + 8 * k);
         prog[src] = reg_jump(idx, off[5:0]);
         base_val[idx] = dst - {{10{off[5]}}, off[5:0]};
      end
      prog[8'hcc] = imm_jump(16'hcc, 16'hc0);
   endtask

   ////////////////////
   // drive helpers
   ////////////////////
   // next falling edge, pulses cleared
   task automatic step();
      @(negedge clk);
      load_en = 1'b0;
      reg_wr_en = 1'b0;
      redirect_en = 1'b0;
   endtask

   task automatic load_word(addr_t a, word_t d);
      step();
      load_en = 1'b1;
      load_addr = a;
      load_data = d;
   endtask

   task automatic redirect_to(addr_t pc);
      step();
      redirect_en = 1'b1;
      redirect_pc = pc;
   endtask

   task automatic start_test(int id);
      step();
      test_id = id;
   endtask

   task automatic wait_bundles(int n);
      int goal;
      goal = test_bundles + n;
      while (test_bundles < goal)
         step();
   endtask

   ////////////////////
   // clock, timeout
   ////////////////////
   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit) begin
         $display("timeout: bundle stream stalled, run stopped after %0d cycles", cycle);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // credits go back in order, each after its delay
   always @(negedge clk) begin
      if (bundle_valid) begin
         if (slow_credits) begin
            credit_due.push_back(cycle + delay_tab[credit_idx % 64]);
            credit_idx++;
         end else begin
            credit_due.push_back(cycle);
         end
      end
      credit_return = 1'b0;
      if (credit_due.size() > 0 && cycle >= credit_due[0]) begin
         credit_return = 1'b1;
         void'(credit_due.pop_front());
      end
   end

   fetch_top UUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_en       (load_en),
      .load_addr     (load_addr),
      .load_data     (load_data),
      .reg_wr_en     (reg_wr_en),
      .reg_wr_idx    (reg_wr_idx),
      .reg_wr_data   (reg_wr_data),
      .redirect_en   (redirect_en),
      .redirect_pc   (redirect_pc),
      .credit_return (credit_return),
      .bundle_valid  (bundle_valid),
      .bundle_pc     (bundle_pc),
      .bundle_word0  (bundle_word0),
      .bundle_word1  (bundle_word1),
      .bundle_word2  (bundle_word2),
      .bundle_word3  (bundle_word3)
   );

   fetch_checker u_checker (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_en       (load_en),
      .load_addr     (load_addr),
      .load_data     (load_data),
      .reg_wr_en     (reg_wr_en),
      .reg_wr_idx    (reg_wr_idx),
      .reg_wr_data   (reg_wr_data),
      .redirect_en   (redirect_en),
      .redirect_pc   (redirect_pc),
      .credit_return (credit_return),
      .bundle_valid  (bundle_valid),
      .bundle_pc     (bundle_pc),
      .bundle_word0  (bundle_word0),
      .bundle_word1  (bundle_word1),
      .bundle_word2  (bundle_word2),
      .bundle_word3  (bundle_word3),
      .test_id       (test_id),
      .test_bundles  (test_bundles),
      .total_bundles (total_bundles),
      .total_errors  (total_errors)
   );

   ////////////////////
   // test sequence
   ////////////////////
   initial begin
      rst_n = 1'b0;
      load_en = 1'b0;
      load_addr = '0;
      load_data = '0;
      reg_wr_en = 1'b0;
      reg_wr_idx = '0;
      reg_wr_data = '0;
      redirect_en = 1'b0;
      redirect_pc = '0;
      credit_return = 1'b0;
      // short waits mostly, now and then a long pause
      for (int i = 0; i < 64; i++)
         delay_tab[i] = int'(rand_bits(3)) + ((rand_bits(3) == 0) ? 24 : 0);
      build_program();
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      // fetch runs on garbage meanwhile, checker not yet synced
      for (int a = 0; a < imem_depth; a++)
         load_word(addr_t'(a), prog[a]);
      for (int r = 0; r < 16; r++) begin
         step();
         reg_wr_en = 1'b1;
         reg_wr_idx = reg_idx_t'(r);
         reg_wr_data = base_val[r];
      end
      step();

      start_test(1);
      redirect_to(16'h00);
      wait_bundles(n_straight);

      start_test(2);
      redirect_to(16'h40);
      wait_bundles(n_imm);

      start_test(3);
      redirect_to(16'h80);
      wait_bundles(n_reg);

      start_test(4);
      slow_credits <= 1'b1;
      redirect_to(16'h00);
      wait_bundles(n_credit);
      slow_credits <= 1'b0;

      // mid stream, then at each step of a register jump
      start_test(5);
      redirect_to(16'h00);
      wait_bundles(4);
      redirect_to(16'h30);
      wait_bundles(4);
      for (int d = 1; d <= 4; d++) begin
         redirect_to(16'h80);
         repeat (d) step();
         redirect_to(addr_t'(16'h21 + d));
         wait_bundles(3);
      end

      // loop at c0 while e0-ff is rewritten
      start_test(6);
      redirect_to(16'hc0);
      wait_bundles(4);
      for (int a = 16'he0; a <= 16'hff; a++) begin
         prog[a] = filler_word();
         load_word(addr_t'(a), prog[a]);
         if (rand_bits(1) == 1)
            step();
      end
      step();
      redirect_to(16'he0);
      wait_bundles(8);

      start_test(0);
      step();
      step();
      $display("summary: 6 tests, %0d bundles checked, %0d errors",
               total_bundles, total_errors);
      if (total_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
source/fetch_pkg.sv
source/imem_bank.sv
source/imem_arbiter.sv
source/base_reg_file.sv
source/jump_resolver.sv
source/fetch_sequencer.sv
source/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := fetch_tb
FILELIST  := filelist.f
BUILD     := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
